//--- hdl/muldiv_pkg.sv
//**********************************************************
// Multiply/divide unit shared definitions
// Operand and tag widths, RV64M operation codes and the
// iteration counts of the two engines
//**********************************************************
package muldiv_pkg;

    localparam int xlen  = 64;
    localparam int tag_w = 4;

    // Codes follow the RISC-V funct3 field so bit 2 marks the divide class
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } muldiv_op_e;

    localparam int div_steps = xlen;                 // One quotient bit per step
    localparam int mul_steps = xlen / 2;             // Two multiplier bits per step
    localparam int div_cnt_w = $clog2(div_steps);
    localparam int mul_cnt_w = $clog2(mul_steps);
    localparam int mul_acc_w = 2 * xlen + 2;         // Room for the signed multiples

endpackage

//--- hdl/muldiv_req_if.sv
//**********************************************************
// Request channel from the unit top level to one engine
//**********************************************************
`timescale 1ns/10ps

interface muldiv_req_if;
    logic                         valid;
    logic                         ready;
    muldiv_pkg::muldiv_op_e       op;
    logic [muldiv_pkg::xlen-1:0]  a;
    logic [muldiv_pkg::xlen-1:0]  b;
    logic [muldiv_pkg::tag_w-1:0] tag;

    modport source (output valid, output op, output a, output b, output tag, input ready);
    modport engine (input valid, input op, input a, input b, input tag, output ready);
endinterface

//--- hdl/muldiv_result_if.sv
//**********************************************************
// Tagged result channel from one engine to the arbiter
//**********************************************************
`timescale 1ns/10ps

interface muldiv_result_if;
    logic                         valid;
    logic                         ready;
    logic [muldiv_pkg::xlen-1:0]  data;
    logic [muldiv_pkg::tag_w-1:0] tag;

    modport engine  (output valid, output data, output tag, input ready);
    modport arbiter (input valid, input data, input tag, output ready);
endinterface

//--- hdl/serial_divider.sv
//**********************************************************
// Radix-2 restoring divider for DIV, DIVU, REM and REMU
// Divides absolute values one bit per cycle, fixes signs at
// the end and short-cuts division by zero and overflow
//**********************************************************
`timescale 1ns/10ps

module serial_divider (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    muldiv_req_if.engine    req,
    muldiv_result_if.engine res
);

    logic                                 load_q;
    logic                                 run_q;
    logic                                 fix_q;
    logic                                 done_q;
    logic [muldiv_pkg::div_cnt_w-1:0]     cnt_q;
    logic [2*muldiv_pkg::xlen-1:0]        part_q;      // Remainder over dividend and quotient
    logic [muldiv_pkg::xlen-1:0]          dvsr_q;
    logic [muldiv_pkg::xlen-1:0]          dividend_q;
    logic                                 neg_a_q;
    logic                                 neg_b_q;
    logic                                 is_rem_q;
    logic [muldiv_pkg::tag_w-1:0]         tag_q;
    logic [muldiv_pkg::xlen-1:0]          data_q;

    logic                                 accept;
    logic                                 a_neg;
    logic                                 b_neg;
    logic [muldiv_pkg::xlen-1:0]          a_abs;
    logic [muldiv_pkg::xlen-1:0]          b_abs;
    logic [muldiv_pkg::xlen+1:0]          diff;
    logic                                 borrow;
    logic                                 last_step;
    logic                                 div0;
    logic                                 ovf;
    logic                                 special;
    logic [muldiv_pkg::xlen-1:0]          quot_fix;
    logic [muldiv_pkg::xlen-1:0]          rem_fix;
    logic [muldiv_pkg::xlen-1:0]          result;

    assign req.ready = ~(load_q | run_q | fix_q | done_q);   // Idle only
    assign accept    = req.valid & req.ready;

    assign a_neg = ~req.op[0] & req.a[muldiv_pkg::xlen-1];    // Signed forms have bit 0 clear
    assign b_neg = ~req.op[0] & req.b[muldiv_pkg::xlen-1];
    assign a_abs = a_neg ? -req.a : req.a;
    assign b_abs = b_neg ? -req.b : req.b;

    // Trial subtraction of the divisor from the shifted upper remainder
    assign diff   = {1'b0, part_q[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen-1]} - {2'b00, dvsr_q};
    assign borrow = diff[muldiv_pkg::xlen+1];

    assign last_step = (cnt_q == muldiv_pkg::div_cnt_w'(muldiv_pkg::div_steps - 1));

    assign div0    = (dvsr_q == '0);
    assign ovf     = neg_a_q & neg_b_q & (dvsr_q == {{(muldiv_pkg::xlen-1){1'b0}}, 1'b1})
                   & (dividend_q == {1'b1, {(muldiv_pkg::xlen-1){1'b0}}});
    assign special = div0 | ovf;

    assign quot_fix = (neg_a_q ^ neg_b_q) ? -part_q[muldiv_pkg::xlen-1:0]
                                          : part_q[muldiv_pkg::xlen-1:0];
    assign rem_fix  = neg_a_q ? -part_q[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
                              : part_q[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];

    always_comb begin
        if (div0) begin
            result = is_rem_q ? dividend_q : '1;
        end else if (ovf) begin
            result = is_rem_q ? '0 : dividend_q;
        end else begin
            result = is_rem_q ? rem_fix : quot_fix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            run_q  <= 1'b0;
            fix_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (flush) begin
            load_q <= 1'b0;
            run_q  <= 1'b0;
            fix_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            load_q <= accept;
            run_q  <= (load_q & ~special) | (run_q & ~last_step);
            fix_q  <= (load_q & special) | (run_q & last_step);   // Special cases skip the steps
            done_q <= fix_q | (done_q & ~res.ready);
            cnt_q  <= run_q ? cnt_q + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            part_q     <= {{muldiv_pkg::xlen{1'b0}}, a_abs};
            dvsr_q     <= b_abs;
            dividend_q <= req.a;
            neg_a_q    <= a_neg;
            neg_b_q    <= b_neg;
            is_rem_q   <= req.op[1];
            tag_q      <= req.tag;
        end else if (run_q) begin
            if (borrow) begin
                part_q <= {part_q[2*muldiv_pkg::xlen-2:0], 1'b0};
            end else begin
                part_q <= {diff[muldiv_pkg::xlen-1:0], part_q[muldiv_pkg::xlen-2:0], 1'b1};
            end
        end
        if (fix_q) begin
            data_q <= result;
        end
    end

    assign res.valid = done_q;
    assign res.data  = data_q;
    assign res.tag   = tag_q;

endmodule

//--- hdl/shift_add_multiplier.sv
//**********************************************************
// Shift-add multiplier for MUL, MULH, MULHSU and MULHU
// Retires two multiplier bits per cycle into a wide
// accumulator and returns the low or high product word
//**********************************************************
`timescale 1ns/10ps

module shift_add_multiplier (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    muldiv_req_if.engine    req,
    muldiv_result_if.engine res
);

    logic                             load_q;
    logic                             run_q;
    logic                             fin_q;
    logic                             done_q;
    logic [muldiv_pkg::mul_cnt_w-1:0] cnt_q;
    logic [muldiv_pkg::mul_acc_w-1:0] mcand_q;
    logic [muldiv_pkg::mul_acc_w-1:0] m3_q;           // Three times the multiplicand
    logic [muldiv_pkg::mul_acc_w-1:0] acc_q;
    logic [muldiv_pkg::xlen-1:0]      mplr_q;
    logic                             b_signed_q;
    logic                             hi_q;
    logic [muldiv_pkg::tag_w-1:0]     tag_q;
    logic [muldiv_pkg::xlen-1:0]      data_q;

    logic                             accept;
    logic                             a_sext;
    logic                             last_step;
    logic                             top_neg;
    logic [muldiv_pkg::mul_acc_w-1:0] m2;
    logic [muldiv_pkg::mul_acc_w-1:0] addend;

    assign req.ready = ~(load_q | run_q | fin_q | done_q);
    assign accept    = req.valid & req.ready;
    assign a_sext    = (req.op == muldiv_pkg::op_mulh) | (req.op == muldiv_pkg::op_mulhsu);

    assign last_step = (cnt_q == muldiv_pkg::mul_cnt_w'(muldiv_pkg::mul_steps - 1));
    assign top_neg   = b_signed_q & last_step;   // Top pair of a signed b carries negative weight
    assign m2        = {mcand_q[muldiv_pkg::mul_acc_w-2:0], 1'b0};

    always_comb begin
        case (mplr_q[1:0])
            2'b00:   addend = '0;
            2'b01:   addend = mcand_q;
            2'b10:   addend = top_neg ? -m2 : m2;
            default: addend = top_neg ? -mcand_q : m3_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            run_q  <= 1'b0;
            fin_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (flush) begin
            load_q <= 1'b0;
            run_q  <= 1'b0;
            fin_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            load_q <= accept;
            run_q  <= load_q | (run_q & ~last_step);
            fin_q  <= run_q & last_step;
            done_q <= fin_q | (done_q & ~res.ready);
            cnt_q  <= run_q ? cnt_q + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q    <= {{(muldiv_pkg::xlen+2){a_sext & req.a[muldiv_pkg::xlen-1]}}, req.a};
            mplr_q     <= req.b;
            b_signed_q <= (req.op == muldiv_pkg::op_mulh);
            hi_q       <= (req.op != muldiv_pkg::op_mul);
            tag_q      <= req.tag;
        end else if (load_q) begin
            m3_q  <= mcand_q + m2;
            acc_q <= '0;
        end else if (run_q) begin
            acc_q   <= acc_q + addend;
            mcand_q <= {mcand_q[muldiv_pkg::mul_acc_w-3:0], 2'b00};
            m3_q    <= {m3_q[muldiv_pkg::mul_acc_w-3:0], 2'b00};
            mplr_q  <= {2'b00, mplr_q[muldiv_pkg::xlen-1:2]};
        end
        if (fin_q) begin
            data_q <= hi_q ? acc_q[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
                           : acc_q[muldiv_pkg::xlen-1:0];
        end
    end

    assign res.valid = done_q;
    assign res.data  = data_q;
    assign res.tag   = tag_q;

endmodule

//--- hdl/result_arbiter.sv
//**********************************************************
// Round-robin arbiter for the shared response bus
// Locks the grant while a granted result is back-pressured
//**********************************************************
`timescale 1ns/10ps

module result_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    muldiv_result_if.arbiter             mul_res,
    muldiv_result_if.arbiter             div_res,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic [muldiv_pkg::xlen-1:0]  resp_data,
    output logic [muldiv_pkg::tag_w-1:0] resp_tag
);

    logic last_q;       // High when the divider won the last transfer
    logic lock_q;
    logic lock_sel_q;
    logic sel_free;
    logic sel;          // High selects the divider

    assign sel_free = (mul_res.valid & div_res.valid) ? ~last_q : div_res.valid;
    assign sel      = lock_q ? lock_sel_q : sel_free;

    assign resp_valid    = sel ? div_res.valid : mul_res.valid;
    assign resp_data     = sel ? div_res.data : mul_res.data;
    assign resp_tag      = sel ? div_res.tag : mul_res.tag;
    assign div_res.ready = sel & resp_ready;
    assign mul_res.ready = ~sel & resp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q     <= 1'b0;
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else if (resp_valid && resp_ready) begin
            last_q <= sel;
            lock_q <= 1'b0;
        end else if (resp_valid) begin
            lock_q     <= 1'b1;
            lock_sel_q <= sel;
        end else begin
            lock_q <= 1'b0;   // A flushed engine releases the lock
        end
    end

endmodule

//--- hdl/muldiv_unit.sv
//**********************************************************
// RV64M multiply/divide unit top level
// Steers requests to the multiplier or divider by operation
// class and merges their results on one response bus
//**********************************************************
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  muldiv_pkg::muldiv_op_e       req_op,
    input  logic [muldiv_pkg::xlen-1:0]  req_a,
    input  logic [muldiv_pkg::xlen-1:0]  req_b,
    input  logic [muldiv_pkg::tag_w-1:0] req_tag,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic [muldiv_pkg::xlen-1:0]  resp_data,
    output logic [muldiv_pkg::tag_w-1:0] resp_tag
);

    logic is_div;

    muldiv_req_if    mul_req ();
    muldiv_req_if    div_req ();
    muldiv_result_if mul_res ();
    muldiv_result_if div_res ();

    assign is_div = req_op[2];   // Divide class sits in the upper half of the codes

    assign mul_req.valid = req_valid & ~is_div;
    assign mul_req.op    = req_op;
    assign mul_req.a     = req_a;
    assign mul_req.b     = req_b;
    assign mul_req.tag   = req_tag;

    assign div_req.valid = req_valid & is_div;
    assign div_req.op    = req_op;
    assign div_req.a     = req_a;
    assign div_req.b     = req_b;
    assign div_req.tag   = req_tag;

    assign req_ready = is_div ? div_req.ready : mul_req.ready;

    shift_add_multiplier mul_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .req   (mul_req),
        .res   (mul_res)
    );

    serial_divider div_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .req   (div_req),
        .res   (div_res)
    );

    result_arbiter arb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_res    (mul_res),
        .div_res    (div_res),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .resp_tag   (resp_tag)
    );

endmodule

//--- sim/clock_gen.sv
//**********************************************************
// Testbench clock and power-on reset generator
//**********************************************************
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 4;     // 8 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                    // Released away from the active edge
    end

endmodule

//--- sim/muldiv_tb.sv
//**********************************************************
// Testbench for the RV64M multiply/divide unit
// Random tagged requests with back-pressure and flushes,
// checked against a RISC-V reference model
//**********************************************************
`timescale 1ns/10ps

module muldiv_tb;

    localparam int n_ops      = 300;
    localparam int timeout_ns = (n_ops * 70 + 2000) * 8;   // Slowest operation plus margin

    logic                            clk;
    logic                            rst_n;
    logic                            flush;
    logic                            req_valid;
    logic                            req_ready;
    muldiv_pkg::muldiv_op_e          req_op;
    logic [muldiv_pkg::xlen-1:0]     req_a;
    logic [muldiv_pkg::xlen-1:0]     req_b;
    logic [muldiv_pkg::tag_w-1:0]    req_tag;
    logic                            resp_valid;
    logic                            resp_ready;
    logic [muldiv_pkg::xlen-1:0]     resp_data;
    logic [muldiv_pkg::tag_w-1:0]    resp_tag;

    logic [muldiv_pkg::xlen-1:0]     expected [2**muldiv_pkg::tag_w];
    logic [2**muldiv_pkg::tag_w-1:0] pending;   // Accepted tags that have not returned
    logic [muldiv_pkg::tag_w-1:0]    next_tag;
    logic                            taken;
    int                              issued  = 0;
    int                              checks  = 0;
    int                              errors  = 0;
    int                              flushes = 0;

    clock_gen clk_i (.clk(clk), .rst_n(rst_n));

    muldiv_unit dut_i (.*);

    // Division by zero and overflow take precedence over the RISC-V arithmetic rules
    function automatic logic [63:0] expected_result(input muldiv_pkg::muldiv_op_e op,
                                                    input logic [63:0] a,
                                                    input logic [63:0] b);
        logic [127:0]       prod;
        logic signed [63:0] sres;
        logic               ovf;
        ovf = (a == 64'h8000_0000_0000_0000) && (b == '1);
        if (op[2] && b == '0) begin
            return op[1] ? a : '1;
        end
        if (op[2] && !op[0] && ovf) begin
            return op[1] ? '0 : a;
        end
        case (op)
            muldiv_pkg::op_mul:    prod = {64'd0, a} * {64'd0, b};
            muldiv_pkg::op_mulh:   prod = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
            muldiv_pkg::op_mulhsu: prod = $signed({{64{a[63]}}, a}) * $signed({64'd0, b});
            muldiv_pkg::op_mulhu:  prod = {64'd0, a} * {64'd0, b};
            muldiv_pkg::op_div: begin
                sres = $signed(a) / $signed(b);
                return sres;
            end
            muldiv_pkg::op_rem: begin
                sres = $signed(a) % $signed(b);   // Sign follows the dividend
                return sres;
            end
            muldiv_pkg::op_divu:   return a / b;
            default:               return a % b;
        endcase
        return (op == muldiv_pkg::op_mul) ? prod[63:0] : prod[127:64];
    endfunction

    task automatic pick_operands(output logic [63:0] a, output logic [63:0] b);
        int unsigned kind;
        kind = $urandom % 10;
        a    = {$urandom, $urandom};
        b    = {$urandom, $urandom};
        if (kind == 0) begin
            b = '0;
        end else if (kind == 1) begin
            a = 64'h8000_0000_0000_0000;
            b = '1;
        end else if (kind == 2) begin
            b = 64'($urandom % 16);
        end else if (kind == 3) begin
            b = -64'($urandom % 16);
        end
    endtask

    task automatic drive_cycle();
        logic [2:0] op_bits;
        if (taken) begin
            req_valid = 1'b0;
            taken     = 1'b0;
        end
        flush      = (pending != '0) && ($urandom % 600 == 0);
        resp_ready = ($urandom % 4 != 0);
        if (flush) begin
            flushes++;
        end
        if (!req_valid && issued < n_ops) begin   // One accepted with a flush is discarded
            op_bits = 3'($urandom % 8);
            req_op  = muldiv_pkg::muldiv_op_e'(op_bits);
            pick_operands(req_a, req_b);
            req_tag   = next_tag;
            next_tag  = next_tag + 1'b1;
            req_valid = 1'b1;
            issued++;
        end
    endtask

    // Looks at the values that the coming rising edge will transfer
    task automatic sample_cycle();
        if (req_valid && req_ready) begin
            expected[req_tag] = expected_result(req_op, req_a, req_b);
            pending[req_tag]  = 1'b1;
            taken             = 1'b1;
        end
        if (resp_valid && resp_ready) begin
            checks++;
            if (pending[resp_tag]) begin
                value_check: assert (resp_data == expected[resp_tag]) else begin
                    errors++;
                    $display("ERR %0t: tag %0d returned %h, expected %h",
                             $time, resp_tag, resp_data, expected[resp_tag]);
                end
            end
            tag_check: assert (pending[resp_tag]) else begin
                errors++;
                $display("ERR %0t: tag %0d returned while not outstanding", $time, resp_tag);
            end
            pending[resp_tag] = 1'b0;
        end
        if (flush) begin
            pending = '0;
        end
    endtask

    property stalled_response_holds;
        @(posedge clk) disable iff (!rst_n)
            resp_valid && !resp_ready && !flush |=>
                resp_valid && $stable(resp_data) && $stable(resp_tag);
    endproperty

    hold_check: assert property (stalled_response_holds) else begin
        errors++;
        $display("ERR %0t: response changed while stalled", $time);
    end

    flush_ready_check: assert property (@(posedge clk) disable iff (!rst_n) flush |=> req_ready)
    else begin
        errors++;
        $display("ERR %0t: req_ready low after flush", $time);
    end

    initial begin
        void'($urandom(32'h91a3));
        flush      = 1'b0;
        req_valid  = 1'b0;
        req_op     = muldiv_pkg::op_mul;
        req_a      = '0;
        req_b      = '0;
        req_tag    = '0;
        resp_ready = 1'b0;
        pending    = '0;
        next_tag   = '0;
        taken      = 1'b0;
        wait (rst_n);
        #1;
        reset_check: assert (!resp_valid && req_ready) else begin
            errors++;
            $display("ERR %0t: resp_valid or req_ready wrong after reset", $time);
        end
        while (issued < n_ops || req_valid || pending != '0) begin
            @(negedge clk);
            drive_cycle();
            #1;
            sample_cycle();
        end
        $display("Issued %0d, responses %0d, flushes %0d, errors %0d",
                 issued, checks, flushes, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog.f
hdl/muldiv_pkg.sv
hdl/muldiv_req_if.sv
hdl/muldiv_result_if.sv
hdl/serial_divider.sv
hdl/shift_add_multiplier.sv
hdl/result_arbiter.sv
hdl/muldiv_unit.sv
sim/clock_gen.sv
sim/muldiv_tb.sv

//--- Makefile
# Verilator build and run of the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "No result in $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
